// File: pipeTypesPkg.sv
package pipeTypesPkg;

	// Datapath and address width.
	localparam int XLEN = 32;

	// Instruction field widths.
	localparam int REG_BITS = 5;
	localparam int OPC_BITS = 6;
	localparam int FUNCT_BITS = 6;
	localparam int IMM_BITS = 16;

	// Primary opcode values of the decoded instructions.
	localparam logic [OPC_BITS-1:0] OPC_SPECIAL = 6'h00;
	localparam logic [OPC_BITS-1:0] OPC_LH = 6'h21;
	localparam logic [OPC_BITS-1:0] OPC_LW = 6'h23;
	localparam logic [OPC_BITS-1:0] OPC_SH = 6'h29;
	localparam logic [OPC_BITS-1:0] OPC_SW = 6'h2b;

	// Funct value of ADD under the SPECIAL opcode.
	localparam logic [FUNCT_BITS-1:0] FUNCT_ADD = 6'h20;

	// OP_NOP is zero so a cleared stage register reads as a bubble.
	typedef enum logic [2:0] {
		OP_NOP = 3'd0,
		OP_ADD = 3'd1,
		OP_LW = 3'd2,
		OP_LH = 3'd3,
		OP_SW = 3'd4,
		OP_SH = 3'd5,
		OP_BAD = 3'd6
	} opKind;

	typedef enum logic {SZ_WORD = 1'b0, SZ_HALF = 1'b1} memSize;

endpackage

// File: excPkg.sv
package excPkg;

	// MIPS cause register codes for the exceptions this core detects.
	typedef enum logic [4:0] {
		EXC_NONE = 5'd0,
		EXC_ADEL = 5'd4,
		EXC_ADES = 5'd5,
		EXC_RI = 5'd10,
		EXC_OV = 5'd12
	} excCode;

	// Boot ROM entry point.
	localparam logic [31:0] RESET_PC_DEF = 32'hbfc0_0000;

	// General exception entry while BEV is set.
	localparam logic [31:0] EXC_VECTOR_DEF = 32'hbfc0_0380;

endpackage

// File: pcReg.sv
`timescale 1ns/1ps

module pcReg #(
	parameter logic [pipeTypesPkg::XLEN-1:0] resetPc = excPkg::RESET_PC_DEF,
	parameter logic [pipeTypesPkg::XLEN-1:0] excVector = excPkg::EXC_VECTOR_DEF
) (
	input logic clk,
	input logic rst,
	input logic pcWr,
	input logic excTake,
	input logic redirect,
	input logic [pipeTypesPkg::XLEN-1:0] redirectPc,
	output logic [pipeTypesPkg::XLEN-1:0] pc,
	output logic fetchAdel
);

	// An exception beats a redirect, which beats sequential fetch.
	always_ff @(posedge clk) begin
		if (!rst) begin
			pc <= resetPc;
		end else if (pcWr) begin
			if (excTake)
				pc <= excVector;
			else if (redirect)
				pc <= redirectPc;
			else
				pc <= pc + pipeTypesPkg::XLEN'(4);
		end
	end

	// Instruction fetches must be word aligned.
	assign fetchAdel = (pc[1:0] != 2'b00);

endmodule

// File: ifIdReg.sv
`timescale 1ns/1ps

module ifIdReg (
	input logic clk,
	input logic rst,
	input logic wr,
	input logic flush,
	input logic [pipeTypesPkg::XLEN-1:0] pc,
	input logic [pipeTypesPkg::XLEN-1:0] instr,
	input logic [pipeTypesPkg::XLEN-1:0] rsVal,
	input logic [pipeTypesPkg::XLEN-1:0] rtVal,
	input logic fetchAdel,
	output logic idValid,
	output logic [pipeTypesPkg::XLEN-1:0] idPc,
	output logic [pipeTypesPkg::XLEN-1:0] idInstr,
	output logic [pipeTypesPkg::XLEN-1:0] idRs,
	output logic [pipeTypesPkg::XLEN-1:0] idRt,
	output logic idAdel
);

	// A cleared entry holds an all-zero word, which decodes as a NOP.
	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			idValid <= 1'b0;
			idPc <= '0;
			idInstr <= '0;
			idRs <= '0;
			idRt <= '0;
			idAdel <= 1'b0;
		end else if (wr) begin
			idValid <= 1'b1;
			idPc <= pc;
			idInstr <= instr;
			idRs <= rsVal;
			idRt <= rtVal;
			idAdel <= fetchAdel;
		end
	end

endmodule

// File: idExStage.sv
`timescale 1ns/1ps

module idExStage (
	input logic clk,
	input logic rst,
	input logic wr,
	input logic flush,
	input logic idValid,
	input logic [pipeTypesPkg::XLEN-1:0] idPc,
	input logic [pipeTypesPkg::XLEN-1:0] idInstr,
	input logic [pipeTypesPkg::XLEN-1:0] idRs,
	input logic [pipeTypesPkg::XLEN-1:0] idRt,
	input logic idAdel,
	output logic exValid,
	output logic [pipeTypesPkg::XLEN-1:0] exPc,
	output pipeTypesPkg::opKind exOp,
	output pipeTypesPkg::memSize exSize,
	output logic [pipeTypesPkg::REG_BITS-1:0] exRd,
	output logic [pipeTypesPkg::XLEN-1:0] exA,
	output logic [pipeTypesPkg::XLEN-1:0] exB,
	output logic [pipeTypesPkg::XLEN-1:0] exImm,
	output excPkg::excCode exExc
);

	logic [pipeTypesPkg::OPC_BITS-1:0] opc;
	logic [pipeTypesPkg::FUNCT_BITS-1:0] funct;
	pipeTypesPkg::opKind op;
	pipeTypesPkg::memSize size;
	logic [pipeTypesPkg::REG_BITS-1:0] rd;
	logic [pipeTypesPkg::XLEN-1:0] imm;
	excPkg::excCode exc;

	assign opc = idInstr[pipeTypesPkg::XLEN-1 -: pipeTypesPkg::OPC_BITS];
	assign funct = idInstr[pipeTypesPkg::FUNCT_BITS-1:0];

	always_comb begin
		op = pipeTypesPkg::OP_BAD;
		if (idInstr == '0) begin
			op = pipeTypesPkg::OP_NOP;
		end else begin
			case (opc)
				pipeTypesPkg::OPC_SPECIAL:
					if (funct == pipeTypesPkg::FUNCT_ADD)
						op = pipeTypesPkg::OP_ADD;
				pipeTypesPkg::OPC_LW: op = pipeTypesPkg::OP_LW;
				pipeTypesPkg::OPC_LH: op = pipeTypesPkg::OP_LH;
				pipeTypesPkg::OPC_SW: op = pipeTypesPkg::OP_SW;
				pipeTypesPkg::OPC_SH: op = pipeTypesPkg::OP_SH;
				default: op = pipeTypesPkg::OP_BAD;
			endcase
		end
	end

	assign size = (op == pipeTypesPkg::OP_LH || op == pipeTypesPkg::OP_SH) ?
		pipeTypesPkg::SZ_HALF : pipeTypesPkg::SZ_WORD;

	assign imm = {{(pipeTypesPkg::XLEN - pipeTypesPkg::IMM_BITS){idInstr[pipeTypesPkg::IMM_BITS-1]}},
		idInstr[pipeTypesPkg::IMM_BITS-1:0]};

	// ADD writes rd, loads write rt; everything else writes nothing.
	always_comb begin
		rd = '0;
		if (op == pipeTypesPkg::OP_ADD)
			rd = idInstr[15:11];
		else if (op == pipeTypesPkg::OP_LW || op == pipeTypesPkg::OP_LH)
			rd = idInstr[20:16];
	end

	// A fetch error outranks whatever the fetched word decodes to.
	always_comb begin
		exc = excPkg::EXC_NONE;
		if (idValid && idAdel)
			exc = excPkg::EXC_ADEL;
		else if (idValid && op == pipeTypesPkg::OP_BAD)
			exc = excPkg::EXC_RI;
	end

	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			exValid <= 1'b0;
			exOp <= pipeTypesPkg::OP_NOP;
			exSize <= pipeTypesPkg::SZ_WORD;
			exExc <= excPkg::EXC_NONE;
		end else if (wr) begin
			exValid <= idValid;
			exOp <= op;
			exSize <= size;
			exExc <= exc;
		end
	end

	always_ff @(posedge clk) begin
		if (wr) begin
			exPc <= idPc;
			exRd <= rd;
			exA <= idRs;
			exB <= idRt;
			exImm <= imm;
		end
	end

endmodule

// File: exMemStage.sv
`timescale 1ns/1ps

module exMemStage (
	input logic clk,
	input logic rst,
	input logic wr,
	input logic flush,
	input logic exValid,
	input logic [pipeTypesPkg::XLEN-1:0] exPc,
	input pipeTypesPkg::opKind exOp,
	input pipeTypesPkg::memSize exSize,
	input logic [pipeTypesPkg::REG_BITS-1:0] exRd,
	input logic [pipeTypesPkg::XLEN-1:0] exA,
	input logic [pipeTypesPkg::XLEN-1:0] exB,
	input logic [pipeTypesPkg::XLEN-1:0] exImm,
	input excPkg::excCode exExc,
	output logic memValid,
	output logic [pipeTypesPkg::XLEN-1:0] memPc,
	output pipeTypesPkg::opKind memOp,
	output logic [pipeTypesPkg::REG_BITS-1:0] memRd,
	output logic [pipeTypesPkg::XLEN-1:0] memResult,
	output logic memExc,
	output excPkg::excCode memCode,
	output logic [pipeTypesPkg::XLEN-1:0] memBadAddr
);

	localparam int MSB = pipeTypesPkg::XLEN - 1;

	logic isAdd;
	logic isLoad;
	logic isStore;
	logic [MSB:0] addend;
	logic [MSB:0] sum;
	logic overflow;
	logic misaligned;
	excPkg::excCode code;
	logic [MSB:0] badAddr;

	assign isAdd = (exOp == pipeTypesPkg::OP_ADD);
	assign isLoad = (exOp == pipeTypesPkg::OP_LW || exOp == pipeTypesPkg::OP_LH);
	assign isStore = (exOp == pipeTypesPkg::OP_SW || exOp == pipeTypesPkg::OP_SH);

	// Memory operations form their effective address in the same adder.
	assign addend = isAdd ? exB : exImm;
	assign sum = exA + addend;

	// Signed overflow means equal operand signs and a result sign that differs.
	assign overflow = isAdd && (exA[MSB] == exB[MSB]) && (sum[MSB] != exA[MSB]);

	assign misaligned = (exSize == pipeTypesPkg::SZ_WORD) ? (sum[1:0] != 2'b00) : sum[0];

	always_comb begin
		code = excPkg::EXC_NONE;
		badAddr = '0;
		if (exExc != excPkg::EXC_NONE) begin
			code = exExc;
			badAddr = exPc;
		end else if (overflow) begin
			code = excPkg::EXC_OV;
		end else if (isStore && misaligned) begin
			code = excPkg::EXC_ADES;
			badAddr = sum;
		end else if (isLoad && misaligned) begin
			code = excPkg::EXC_ADEL;
			badAddr = sum;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			memValid <= 1'b0;
			memOp <= pipeTypesPkg::OP_NOP;
			memExc <= 1'b0;
			memCode <= excPkg::EXC_NONE;
		end else if (wr) begin
			memValid <= exValid;
			memOp <= exOp;
			memExc <= exValid && (code != excPkg::EXC_NONE);
			memCode <= code;
		end
	end

	always_ff @(posedge clk) begin
		if (wr) begin
			memPc <= exPc;
			memRd <= exRd;
			memResult <= sum;
			memBadAddr <= badAddr;
		end
	end

endmodule

// File: memWbReg.sv
`timescale 1ns/1ps

module memWbReg (
	input logic clk,
	input logic rst,
	input logic wr,
	input logic flush,
	input logic memValid,
	input logic [pipeTypesPkg::XLEN-1:0] memPc,
	input pipeTypesPkg::opKind memOp,
	input logic [pipeTypesPkg::REG_BITS-1:0] memRd,
	input logic [pipeTypesPkg::XLEN-1:0] memResult,
	input logic memExc,
	input excPkg::excCode memCode,
	input logic [pipeTypesPkg::XLEN-1:0] memBadAddr,
	output logic retireValid,
	output logic [pipeTypesPkg::XLEN-1:0] retirePc,
	output pipeTypesPkg::opKind retireOp,
	output logic [pipeTypesPkg::REG_BITS-1:0] retireRd,
	output logic [pipeTypesPkg::XLEN-1:0] retireResult,
	output logic retireWrite,
	output logic excValid,
	output excPkg::excCode excCode,
	output logic [pipeTypesPkg::XLEN-1:0] excPc,
	output logic [pipeTypesPkg::XLEN-1:0] badVAddr
);

	logic retVld;
	logic excVld;
	logic rfWr;
	logic [pipeTypesPkg::XLEN-1:0] wbPc;

	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			retVld <= 1'b0;
			excVld <= 1'b0;
			rfWr <= 1'b0;
			retireOp <= pipeTypesPkg::OP_NOP;
			excCode <= excPkg::EXC_NONE;
		end else if (wr) begin
			retVld <= memValid && !memExc;
			excVld <= memValid && memExc;
			rfWr <= memValid && !memExc && (memOp == pipeTypesPkg::OP_ADD ||
				memOp == pipeTypesPkg::OP_LW || memOp == pipeTypesPkg::OP_LH);
			retireOp <= memOp;
			excCode <= memCode;
		end
	end

	always_ff @(posedge clk) begin
		if (wr) begin
			wbPc <= memPc;
			retireRd <= memRd;
			retireResult <= memResult;
			badVAddr <= memBadAddr;
		end
	end

	// A held entry is reported once, in the cycle it finally moves on.
	assign retireValid = retVld && wr;
	assign excValid = excVld && wr;
	assign retireWrite = rfWr && wr;
	assign retirePc = wbPc;
	assign excPc = wbPc;

endmodule

// File: hazardCtrl.sv
`timescale 1ns/1ps

module hazardCtrl (
	input logic stall,
	input logic redirect,
	input logic memExc,
	output logic pcWr,
	output logic ifIdWr,
	output logic idExWr,
	output logic exMemWr,
	output logic memWbWr,
	output logic ifFlush,
	output logic idFlush,
	output logic exFlush,
	output logic memFlush,
	output logic excTake
);

	logic advance;

	// An exception in EX/MEM is taken at once, even under a stall.
	assign excTake = memExc;
	assign advance = !stall;

	// The faulting entry moves into MEM/WB while the PC loads the vector.
	assign pcWr = advance || excTake;
	assign memWbWr = advance || excTake;

	// Younger stages are flushed on an exception, so their enables only follow stall.
	assign ifIdWr = advance;
	assign idExWr = advance;
	assign exMemWr = advance;

	// A redirect drops the word fetched alongside it.
	assign ifFlush = excTake || (redirect && advance);
	assign idFlush = excTake;
	assign exFlush = excTake;

	// MEM/WB keeps the faulting entry, so nothing clears it.
	assign memFlush = 1'b0;

endmodule

// File: pipeTop.sv
`timescale 1ns/1ps

module pipeTop #(
	parameter logic [pipeTypesPkg::XLEN-1:0] resetPc = excPkg::RESET_PC_DEF,
	parameter logic [pipeTypesPkg::XLEN-1:0] excVector = excPkg::EXC_VECTOR_DEF
) (
	input logic clk,
	input logic rst,
	input logic [pipeTypesPkg::XLEN-1:0] instr,
	input logic [pipeTypesPkg::XLEN-1:0] rsVal,
	input logic [pipeTypesPkg::XLEN-1:0] rtVal,
	input logic stall,
	input logic redirect,
	input logic [pipeTypesPkg::XLEN-1:0] redirectPc,
	output logic [pipeTypesPkg::XLEN-1:0] fetchPc,
	output logic retireValid,
	output logic [pipeTypesPkg::XLEN-1:0] retirePc,
	output pipeTypesPkg::opKind retireOp,
	output logic [pipeTypesPkg::REG_BITS-1:0] retireRd,
	output logic [pipeTypesPkg::XLEN-1:0] retireResult,
	output logic retireWrite,
	output logic excValid,
	output excPkg::excCode excCode,
	output logic [pipeTypesPkg::XLEN-1:0] excPc,
	output logic [pipeTypesPkg::XLEN-1:0] badVAddr
);

	localparam int W = pipeTypesPkg::XLEN;
	localparam int R = pipeTypesPkg::REG_BITS;

	logic pcWr, ifIdWr, idExWr, exMemWr, memWbWr;
	logic ifFlush, idFlush, exFlush, memFlush, excTake;
	logic fetchAdel;

	logic idValid, idAdel;
	logic [W-1:0] idPc, idInstr, idRs, idRt;

	logic exValid;
	logic [W-1:0] exPc, exA, exB, exImm;
	logic [R-1:0] exRd;
	pipeTypesPkg::opKind exOp;
	pipeTypesPkg::memSize exSize;
	excPkg::excCode exExc;

	logic memValid, memExc;
	logic [W-1:0] memPc, memResult, memBadAddr;
	logic [R-1:0] memRd;
	pipeTypesPkg::opKind memOp;
	excPkg::excCode memCode;

	pcReg #(.resetPc(resetPc), .excVector(excVector)) i_pcReg (
		.clk(clk), .rst(rst), .pcWr(pcWr), .excTake(excTake), .redirect(redirect),
		.redirectPc(redirectPc), .pc(fetchPc), .fetchAdel(fetchAdel));

	ifIdReg i_ifIdReg (
		.clk(clk), .rst(rst), .wr(ifIdWr), .flush(ifFlush), .pc(fetchPc), .instr(instr),
		.rsVal(rsVal), .rtVal(rtVal), .fetchAdel(fetchAdel), .idValid(idValid),
		.idPc(idPc), .idInstr(idInstr), .idRs(idRs), .idRt(idRt), .idAdel(idAdel));

	idExStage i_idExStage (
		.clk(clk), .rst(rst), .wr(idExWr), .flush(idFlush), .idValid(idValid),
		.idPc(idPc), .idInstr(idInstr), .idRs(idRs), .idRt(idRt), .idAdel(idAdel),
		.exValid(exValid), .exPc(exPc), .exOp(exOp), .exSize(exSize), .exRd(exRd),
		.exA(exA), .exB(exB), .exImm(exImm), .exExc(exExc));

	exMemStage i_exMemStage (
		.clk(clk), .rst(rst), .wr(exMemWr), .flush(exFlush), .exValid(exValid),
		.exPc(exPc), .exOp(exOp), .exSize(exSize), .exRd(exRd), .exA(exA), .exB(exB),
		.exImm(exImm), .exExc(exExc), .memValid(memValid), .memPc(memPc), .memOp(memOp),
		.memRd(memRd), .memResult(memResult), .memExc(memExc), .memCode(memCode),
		.memBadAddr(memBadAddr));

	memWbReg i_memWbReg (
		.clk(clk), .rst(rst), .wr(memWbWr), .flush(memFlush), .memValid(memValid),
		.memPc(memPc), .memOp(memOp), .memRd(memRd), .memResult(memResult),
		.memExc(memExc), .memCode(memCode), .memBadAddr(memBadAddr),
		.retireValid(retireValid), .retirePc(retirePc), .retireOp(retireOp),
		.retireRd(retireRd), .retireResult(retireResult), .retireWrite(retireWrite),
		.excValid(excValid), .excCode(excCode), .excPc(excPc), .badVAddr(badVAddr));

	hazardCtrl i_hazardCtrl (
		.stall(stall), .redirect(redirect), .memExc(memExc), .pcWr(pcWr),
		.ifIdWr(ifIdWr), .idExWr(idExWr), .exMemWr(exMemWr), .memWbWr(memWbWr),
		.ifFlush(ifFlush), .idFlush(idFlush), .exFlush(exFlush), .memFlush(memFlush),
		.excTake(excTake));

endmodule

// File: pipe_assert.sv
`timescale 1ns/1ps

module pipeAssert (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic excTake,
	input logic [31:0] fetchPc,
	input logic retireValid,
	input logic excValid,
	input logic retireWrite
);

	// The faulting entry occupies MEM/WB right after it is taken.
	noRetireAfterExc: assert property (@(posedge clk) disable iff (!rst)
		excTake |=> !retireValid)
		else $error("retire reported in the cycle after an exception was taken");

	oneRecordKind: assert property (@(posedge clk) disable iff (!rst)
		!(retireValid && excValid))
		else $error("retire and exception reported in the same cycle");

	// An exception still moves the PC under a stall.
	pcHoldsInStall: assert property (@(posedge clk) disable iff (!rst)
		stall && !excTake |=> $stable(fetchPc))
		else $error("fetch address moved during a stall");

	quietInReset: assert property (@(posedge clk)
		!rst && $past(!rst) |-> !retireValid && !excValid && !retireWrite)
		else $error("report outputs active during reset");

endmodule

// File: pipeTb.sv
`timescale 1ns/1ps

module pipeTb;

	logic clk;
	logic rst;
	logic [31:0] instr;
	logic [31:0] rsVal;
	logic [31:0] rtVal;
	logic stall;
	logic redirect;
	logic [31:0] redirectPc;
	logic [31:0] fetchPc;
	logic retireValid;
	logic [31:0] retirePc;
	pipeTypesPkg::opKind retireOp;
	logic [4:0] retireRd;
	logic [31:0] retireResult;
	logic retireWrite;
	logic excValid;
	excPkg::excCode excCode;
	logic [31:0] excPc;
	logic [31:0] badVAddr;

	// Holds program words with their operands and repeats every 8 KB.
	logic [95:0] imem [0:2047];
	int redirCycle[$];
	logic [31:0] redirTarget[$];
	logic [31:0] expTest[$];
	logic [31:0] expIsExc[$];
	logic [31:0] expPc[$];
	logic [31:0] expKind[$];
	logic [31:0] expRd[$];
	logic [31:0] expVal[$];
	logic [31:0] expWr[$];
	logic [31:0] curTest;
	int schedLen;
	int stallStart;
	int errCount;
	int testErr;
	int checked;
	int seed;
	bit firstSeen;

	pipeTop i_pipeTop (
		.clk(clk), .rst(rst), .instr(instr), .rsVal(rsVal), .rtVal(rtVal), .stall(stall),
		.redirect(redirect), .redirectPc(redirectPc), .fetchPc(fetchPc),
		.retireValid(retireValid), .retirePc(retirePc), .retireOp(retireOp),
		.retireRd(retireRd), .retireResult(retireResult), .retireWrite(retireWrite),
		.excValid(excValid), .excCode(excCode), .excPc(excPc), .badVAddr(badVAddr));

	bind pipeTop pipeAssert i_pipeAssert (
		.clk(clk), .rst(rst), .stall(stall), .excTake(excTake), .fetchPc(fetchPc),
		.retireValid(retireValid), .excValid(excValid), .retireWrite(retireWrite));

	assign instr = imem[fetchPc[12:2]][95:64];
	assign rsVal = imem[fetchPc[12:2]][63:32];
	assign rtVal = imem[fetchPc[12:2]][31:0];

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic reportErr(input string msg);
		$display("ERR at %0t ns: %s", $time, msg);
		errCount++;
		testErr++;
	endtask

	task automatic loadStimulus();
		int fd;
		int r;
		string tag;
		string rest;
		logic [31:0] f [0:6];
		fd = $fopen("pipe_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open pipe_stimulus.txt, nothing was run");
			errCount++;
			return;
		end
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag == "M") begin
				r = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
				imem[f[0][12:2]] = {f[1], f[2], f[3]};
			end else if (tag == "R") begin
				r = $fscanf(fd, "%d %h", f[0], f[1]);
				redirCycle.push_back(int'(f[0]));
				redirTarget.push_back(f[1]);
			end else if (tag == "L") begin
				r = $fscanf(fd, "%d %d", schedLen, stallStart);
			end else if (tag == "X") begin
				r = $fscanf(fd, "%d %d %h %h %d %h %d", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
				expTest.push_back(f[0]);
				expIsExc.push_back(f[1]);
				expPc.push_back(f[2]);
				expKind.push_back(f[3]);
				expRd.push_back(f[4]);
				expVal.push_back(f[5]);
				expWr.push_back(f[6]);
			end else begin
				r = $fgets(rest, fd);
			end
		end
		$fclose(fd);
	endtask

	task automatic checkRecord(input bit isExc);
		if (expPc.size() == 0) begin
			$display("Unexpected record at %0t ns with no expected entry left", $time);
			errCount++;
			return;
		end
		if (expIsExc[0] != {31'b0, isExc}) begin
			reportErr($sformatf("pc %h gave the wrong record kind", isExc ? excPc : retirePc));
		end else if (isExc) begin
			if (excPc != expPc[0])
				reportErr($sformatf("excPc %h, expected %h", excPc, expPc[0]));
			if (excCode != expKind[0][4:0])
				reportErr($sformatf("excCode %0d, expected %0d", excCode, expKind[0][4:0]));
			if (badVAddr != expVal[0])
				reportErr($sformatf("badVAddr %h, expected %h", badVAddr, expVal[0]));
		end else begin
			if (retirePc != expPc[0])
				reportErr($sformatf("retirePc %h, expected %h", retirePc, expPc[0]));
			if (retireOp != expKind[0][2:0])
				reportErr($sformatf("retireOp %0d, expected %0d", retireOp, expKind[0][2:0]));
			if (retireRd != expRd[0][4:0])
				reportErr($sformatf("retireRd %0d, expected %0d", retireRd, expRd[0][4:0]));
			if (retireResult != expVal[0])
				reportErr($sformatf("retireResult %h, expected %h", retireResult, expVal[0]));
			if (retireWrite != expWr[0][0])
				reportErr($sformatf("retireWrite %b, expected %b", retireWrite, expWr[0][0]));
		end
		curTest = expTest.pop_front();
		void'(expIsExc.pop_front());
		void'(expPc.pop_front());
		void'(expKind.pop_front());
		void'(expRd.pop_front());
		void'(expVal.pop_front());
		void'(expWr.pop_front());
		checked++;
		if (expTest.size() == 0 || expTest[0] != curTest) begin
			$display("Test %0d finished with %0d errors", curTest, testErr);
			testErr = 0;
		end
	endtask

	// NOP retires are bubbles of the program stream and are not recorded.
	always @(posedge clk) begin
		if (rst) begin
			if (!firstSeen) begin
				firstSeen = 1'b1;
				if (fetchPc != excPkg::RESET_PC_DEF)
					reportErr($sformatf("first fetchPc %h, expected reset vector", fetchPc));
			end
			if (excValid)
				checkRecord(1'b1);
			else if (retireValid && retireOp != pipeTypesPkg::OP_NOP)
				checkRecord(1'b0);
		end
	end

	initial begin
		int cycles;
		int limit;
		int sched;
		bit stallNow;
		rst = 1'b0;
		stall = 1'b0;
		redirect = 1'b0;
		redirectPc = '0;
		seed = 32'h6a81e365;
		errCount = 0;
		testErr = 0;
		checked = 0;
		schedLen = 0;
		stallStart = 0;
		for (int i = 0; i < 2048; i++)
			imem[i] = '0;
		loadStimulus();
		limit = schedLen + 64;
		cycles = 0;
		sched = 0;
		repeat (16) @(posedge clk);
		rst <= 1'b1;
		// Schedule entries count unstalled cycles, so a stall only delays them.
		while (cycles < limit && (sched < schedLen || expPc.size() != 0)) begin
			stallNow = (sched >= stallStart) && (sched < schedLen) && ($random(seed) % 4 == 0);
			stall <= stallNow;
			redirect <= 1'b0;
			if (!stallNow && redirCycle.size() != 0 && redirCycle[0] == sched) begin
				redirect <= 1'b1;
				redirectPc <= redirTarget.pop_front();
				void'(redirCycle.pop_front());
			end
			if (!stallNow)
				sched++;
			cycles++;
			@(posedge clk);
		end
		$display("Checked %0d records in %0d cycles, %0d errors", checked, cycles, errCount);
		if (cycles >= limit)
			$display("Run timed out after %0d cycles, %0d records never seen", cycles, expPc.size());
		if (cycles >= limit || errCount != 0)
			$display("ERRORS FOUND");
		else
			$display("NO ERRORS");
		$finish;
	end

endmodule

// File: mipsPipe.f
pipeTypesPkg.sv
excPkg.sv
pcReg.sv
ifIdReg.sv
idExStage.sv
exMemStage.sv
memWbReg.sv
hazardCtrl.sv
pipeTop.sv
pipe_assert.sv
pipeTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= pipeTb
FLIST ?= mipsPipe.f
BUILD ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: pipe_stimulus.txt
# M addr instr rsVal rtVal | R activeCycle target | L scheduleLength stallStart
# X test isExc pc opOrCode rd resultOrBadVAddr write
M bfc00000 00221820 00000005 00000007
M bfc00004 8c240008 00000100 00000000
M bfc00008 84250006 00000100 00000000
M bfc0000c ac26fffc 00000200 00000000
M bfc00010 a4270002 00000200 00000000
M bfc00380 00221820 00000010 00000020
M 00001000 00221820 7fffffff 00000001
M 00001004 00221820 00000001 00000001
M 00001100 8c240001 00000100 00000000
M 00001200 ac260002 00000100 00000000
M 00001300 84250003 00000100 00000000
M 00001400 fc000000 00000000 00000000
M 00001500 00221820 00000001 00000002
M 00001504 00221820 00000009 00000009
M 00001702 00221820 7fffffff 00000001
R 10 00001000
R 18 00001100
R 26 00001200
R 34 00001300
R 42 00001400
R 50 00001500
R 52 00001602
R 60 00001702
R 68 bfc00000
L 84 68
X 1 0 bfc00000 1 3 0000000c 1
X 1 0 bfc00004 2 4 00000108 1
X 1 0 bfc00008 3 5 00000106 1
X 1 0 bfc0000c 4 0 000001fc 0
X 1 0 bfc00010 5 0 00000202 0
X 2 1 00001000 0c 0 00000000 0
X 2 0 bfc00380 1 3 00000030 1
X 2 1 00001100 04 0 00000101 0
X 2 0 bfc00380 1 3 00000030 1
X 2 1 00001200 05 0 00000102 0
X 2 0 bfc00380 1 3 00000030 1
X 2 1 00001300 04 0 00000103 0
X 2 0 bfc00380 1 3 00000030 1
X 3 1 00001400 0a 0 00001400 0
X 3 0 bfc00380 1 3 00000030 1
X 4 0 00001500 1 3 00000003 1
X 4 1 00001602 04 0 00001602 0
X 4 0 bfc00380 1 3 00000030 1
X 6 1 00001702 04 0 00001702 0
X 6 0 bfc00380 1 3 00000030 1
X 5 0 bfc00000 1 3 0000000c 1
X 5 0 bfc00004 2 4 00000108 1
X 5 0 bfc00008 3 5 00000106 1
X 5 0 bfc0000c 4 0 000001fc 0
X 5 0 bfc00010 5 0 00000202 0
